//--- cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// ==================================================
// frame and kernel geometry
// ==================================================
`define CNN_IX      8
`define CNN_IY      8
`define CNN_K       3
`define CNN_OX      (`CNN_IX - `CNN_K + 1)
`define CNN_POOL_O  (`CNN_OX / 2)
`define CNN_CO      2
`define CNN_NTAP    (`CNN_K * `CNN_K)
`define CNN_NPOOL   (`CNN_POOL_O * `CNN_POOL_O)
`define CNN_NPIX    (`CNN_IX * `CNN_IY)
`define CNN_NW      (`CNN_CO * `CNN_NTAP)

// data path widths
`define CNN_PIX_W   8
`define CNN_WGT_W   8
`define CNN_BIAS_W  16
`define CNN_ACC_W   22
`define CNN_FMAP_W  21
`define CNN_PADDR_W 6
`define CNN_IDX_W   4
`define CNN_CH_W    1

// ==================================================
// APB register map, one 32-bit word per entry
// ==================================================
`define CNN_ADDR_W     12
`define CNN_DATA_W     32
`define CNN_REG_CTRL   12'h000
`define CNN_REG_STATUS 12'h004
`define CNN_REG_WEIGHT 12'h040
`define CNN_REG_BIAS   12'h0A0
`define CNN_REG_PIXEL  12'h100
`define CNN_REG_RESULT 12'h200

`endif

//--- cnn_pkg.sv
`include "cnn_defines.svh"

package cnn_pkg;

    typedef logic        [`CNN_PIX_W-1:0]   pixel_t;
    typedef logic signed [`CNN_WGT_W-1:0]   weight_t;
    typedef logic signed [`CNN_BIAS_W-1:0]  bias_t;
    typedef logic signed [`CNN_ACC_W-1:0]   acc_t;
    typedef logic        [`CNN_FMAP_W-1:0]  fmap_t;
    typedef logic        [`CNN_PADDR_W-1:0] pix_addr_t;
    typedef logic        [`CNN_IDX_W-1:0]   tap_idx_t;
    typedef logic        [`CNN_IDX_W-1:0]   pool_idx_t;
    typedef logic        [`CNN_CH_W-1:0]    ch_idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_t;

    // pixel write from the register block into the frame memory
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    pixel;
    } pix_wr_t;

    // one kernel tap of the scan
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        tap_idx_t  tap;
        logic      first_tap;
        logic      last_tap;
        logic      last_quad;
        pool_idx_t pool;
    } tap_t;

    // finished window, all channels side by side
    typedef struct packed {
        logic                      valid;
        logic                      last_quad;
        pool_idx_t                 pool;
        fmap_t [`CNN_CO-1:0]       fmap;
    } conv_out_t;

    typedef struct packed {
        ch_idx_t   ch;
        pool_idx_t pool;
    } res_rd_t;

endpackage

//--- cnn_apb_regs.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_apb_regs (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [`CNN_ADDR_W-1:0]              i_paddr,
    input  logic [`CNN_DATA_W-1:0]              i_pwdata,
    output logic [`CNN_DATA_W-1:0]              o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    input  cnn_pkg::ctrl_state_t                i_state,
    output logic                                o_start,
    output cnn_pkg::pix_wr_t                    o_pix_wr,
    output cnn_pkg::weight_t [`CNN_NW-1:0]      o_weights,
    output cnn_pkg::bias_t   [`CNN_CO-1:0]      o_bias,
    output cnn_pkg::res_rd_t                    o_res_rd,
    input  cnn_pkg::fmap_t                      i_res_data,
    output logic                                o_irq
);

    logic access, wr, busy, done;
    logic in_ctrl, in_status, in_weight, in_bias, in_pixel, in_result;
    logic mapped, wr_refused, res_ch_hi;
    logic [`CNN_ADDR_W-3:0] w_off, b_off, p_off, r_off;
    cnn_pkg::weight_t [`CNN_NW-1:0] r_weights;
    cnn_pkg::bias_t   [`CNN_CO-1:0] r_bias;
    // readback copy of the frame
    cnn_pkg::pixel_t r_frame_copy [`CNN_NPIX];

    function automatic logic in_range(input logic [`CNN_ADDR_W-1:0] addr,
                                      input logic [`CNN_ADDR_W-1:0] base,
                                      input int words);
        return (addr[1:0] == 2'b00) && (addr >= base) && (addr < base + words * 4);
    endfunction

    function automatic logic [`CNN_ADDR_W-3:0] word_off(input logic [`CNN_ADDR_W-1:0] addr,
                                                       input logic [`CNN_ADDR_W-1:0] base);
        logic [`CNN_ADDR_W-1:0] diff;
        diff = addr - base;
        return diff[`CNN_ADDR_W-1:2];
    endfunction

    // ==================================================
    // decode
    // ==================================================
    assign access    = i_psel && i_penable;
    assign wr        = access && i_pwrite;
    assign busy      = (i_state == cnn_pkg::ST_RUN) || (i_state == cnn_pkg::ST_DRAIN);
    assign done      = (i_state == cnn_pkg::ST_DONE);

    assign in_ctrl   = in_range(i_paddr, `CNN_REG_CTRL, 1);
    assign in_status = in_range(i_paddr, `CNN_REG_STATUS, 1);
    assign in_weight = in_range(i_paddr, `CNN_REG_WEIGHT, `CNN_NW);
    assign in_bias   = in_range(i_paddr, `CNN_REG_BIAS, `CNN_CO);
    assign in_pixel  = in_range(i_paddr, `CNN_REG_PIXEL, `CNN_NPIX);
    assign in_result = in_range(i_paddr, `CNN_REG_RESULT, `CNN_CO * `CNN_NPOOL);
    assign mapped    = in_ctrl || in_status || in_weight || in_bias || in_pixel || in_result;

    assign w_off = word_off(i_paddr, `CNN_REG_WEIGHT);
    assign b_off = word_off(i_paddr, `CNN_REG_BIAS);
    assign p_off = word_off(i_paddr, `CNN_REG_PIXEL);
    assign r_off = word_off(i_paddr, `CNN_REG_RESULT);

    // data space and a second start are locked while the core runs
    assign wr_refused = busy && wr && (in_weight || in_bias || in_pixel || (in_ctrl && i_pwdata[0]));

    assign o_pready  = 1'b1;
    assign o_pslverr = access && (!mapped || wr_refused);
    assign o_start   = wr && in_ctrl && i_pwdata[0] && !busy;
    assign o_irq     = done;

    assign o_pix_wr.valid = wr && in_pixel && !busy;
    assign o_pix_wr.addr  = cnn_pkg::pix_addr_t'(p_off);
    assign o_pix_wr.pixel = i_pwdata[`CNN_PIX_W-1:0];

    // result words are channel major
    assign res_ch_hi     = (r_off >= `CNN_NPOOL);
    assign o_res_rd.ch   = res_ch_hi;
    assign o_res_rd.pool = cnn_pkg::pool_idx_t'(res_ch_hi ? r_off - `CNN_NPOOL : r_off);

    // ==================================================
    // weight, bias and frame copy
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_weights <= '0;
            r_bias    <= '0;
        end else begin
            if (wr && !busy && in_weight) begin
                r_weights[w_off] <= i_pwdata[`CNN_WGT_W-1:0];
            end
            if (wr && !busy && in_bias) begin
                r_bias[b_off] <= i_pwdata[`CNN_BIAS_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_pix_wr.valid) begin
            r_frame_copy[o_pix_wr.addr] <= o_pix_wr.pixel;
        end
    end

    assign o_weights = r_weights;
    assign o_bias    = r_bias;

    // read mux, ctrl reads as zero
    always_comb begin
        o_prdata = '0;
        if (in_status) begin
            o_prdata = {{(`CNN_DATA_W-2){1'b0}}, done, busy};
        end else if (in_weight) begin
            o_prdata = {{(`CNN_DATA_W-`CNN_WGT_W){r_weights[w_off][`CNN_WGT_W-1]}},
                        r_weights[w_off]};
        end else if (in_bias) begin
            o_prdata = {{(`CNN_DATA_W-`CNN_BIAS_W){r_bias[b_off][`CNN_BIAS_W-1]}},
                        r_bias[b_off]};
        end else if (in_pixel) begin
            o_prdata = {{(`CNN_DATA_W-`CNN_PIX_W){1'b0}}, r_frame_copy[o_pix_wr.addr]};
        end else if (in_result) begin
            o_prdata = {{(`CNN_DATA_W-`CNN_FMAP_W){1'b0}}, i_res_data};
        end
    end

endmodule

//--- cnn_ctrl_fsm.sv
`timescale 1ns/1ns

module cnn_ctrl_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 i_start,
    input  logic                 i_scan_end,
    input  logic                 i_pool_last_wr,
    output logic                 o_run,
    output cnn_pkg::ctrl_state_t o_state
);

    cnn_pkg::ctrl_state_t r_state, next_state;

    always_comb begin
        next_state = r_state;
        case (r_state)
            cnn_pkg::ST_IDLE, cnn_pkg::ST_DONE: begin
                if (i_start) begin
                    next_state = cnn_pkg::ST_RUN;
                end
            end
            cnn_pkg::ST_RUN: begin
                if (i_scan_end) begin
                    next_state = cnn_pkg::ST_DRAIN;
                end
            end
            // last windows still in the pipe
            cnn_pkg::ST_DRAIN: begin
                if (i_pool_last_wr) begin
                    next_state = cnn_pkg::ST_DONE;
                end
            end
            default: next_state = cnn_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_state <= cnn_pkg::ST_IDLE;
        end else begin
            r_state <= next_state;
        end
    end

    assign o_run   = (r_state == cnn_pkg::ST_RUN);
    assign o_state = r_state;

endmodule

//--- cnn_scan_counter.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_scan_counter (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          i_run,
    output cnn_pkg::tap_t o_tap,
    output logic          o_scan_end
);

    logic [1:0] r_kx, r_ky, r_px, r_py;
    logic       r_qx, r_qy;
    logic       kx_end, ky_end, qx_end, qy_end, px_end, py_end;
    logic [2:0] pix_y, pix_x;

    // carry chain, kernel column innermost
    assign kx_end = (r_kx == `CNN_K - 1);
    assign ky_end = kx_end && (r_ky == `CNN_K - 1);
    assign qx_end = ky_end && r_qx;
    assign qy_end = qx_end && r_qy;
    assign px_end = qy_end && (r_px == `CNN_POOL_O - 1);
    assign py_end = px_end && (r_py == `CNN_POOL_O - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_kx <= '0;
            r_ky <= '0;
            r_qx <= 1'b0;
            r_qy <= 1'b0;
            r_px <= '0;
            r_py <= '0;
        end else if (i_run) begin
            r_kx <= kx_end ? 2'd0 : r_kx + 2'd1;
            if (kx_end) begin
                r_ky <= ky_end ? 2'd0 : r_ky + 2'd1;
            end
            if (ky_end) begin
                r_qx <= ~r_qx;
            end
            if (qx_end) begin
                r_qy <= ~r_qy;
            end
            if (qy_end) begin
                r_px <= px_end ? 2'd0 : r_px + 2'd1;
            end
            if (px_end) begin
                r_py <= py_end ? 2'd0 : r_py + 2'd1;
            end
        end
    end

    // conv position 2*pool + quad, then the kernel offset
    assign pix_y = {r_py, 1'b0} + r_qy + r_ky;
    assign pix_x = {r_px, 1'b0} + r_qx + r_kx;

    assign o_tap.valid     = i_run;
    assign o_tap.addr      = cnn_pkg::pix_addr_t'(pix_y * `CNN_IX + pix_x);
    assign o_tap.tap       = cnn_pkg::tap_idx_t'(r_ky * `CNN_K + r_kx);
    assign o_tap.first_tap = (r_kx == 2'd0) && (r_ky == 2'd0);
    assign o_tap.last_tap  = ky_end;
    assign o_tap.last_quad = r_qx && r_qy;
    assign o_tap.pool      = cnn_pkg::pool_idx_t'(r_py * `CNN_POOL_O + r_px);
    assign o_scan_end      = i_run && py_end;

endmodule

//--- cnn_window_conv.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_window_conv (
    input  logic                           clk,
    input  logic                           reset_n,
    input  cnn_pkg::pix_wr_t               i_pix_wr,
    input  cnn_pkg::tap_t                  i_tap,
    input  cnn_pkg::weight_t [`CNN_NW-1:0] i_weights,
    input  cnn_pkg::bias_t   [`CNN_CO-1:0] i_bias,
    output cnn_pkg::conv_out_t             o_conv
);

    cnn_pkg::pixel_t frame_mem [`CNN_NPIX];
    cnn_pkg::pixel_t r_pix;
    cnn_pkg::tap_t   r_tap;
    cnn_pkg::acc_t   r_acc    [`CNN_CO];
    cnn_pkg::acc_t   acc_next [`CNN_CO];
    cnn_pkg::acc_t   biased   [`CNN_CO];

    // ==================================================
    // frame memory and read register
    // ==================================================
    always_ff @(posedge clk) begin
        if (i_pix_wr.valid) begin
            frame_mem[i_pix_wr.addr] <= i_pix_wr.pixel;
        end
        r_pix <= frame_mem[i_tap.addr];
    end

    // tap markers follow the pixel by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_tap <= '0;
        end else begin
            r_tap <= i_tap;
        end
    end

    // ==================================================
    // multiply-accumulate per channel
    // ==================================================
    always_comb begin
        for (int c = 0; c < `CNN_CO; c++) begin
            acc_next[c] = (r_tap.first_tap ? cnn_pkg::acc_t'(0) : r_acc[c])
                        + $signed({1'b0, r_pix})
                        * $signed(i_weights[c * `CNN_NTAP + r_tap.tap]);
            biased[c]   = acc_next[c] + $signed(i_bias[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (r_tap.valid) begin
            for (int c = 0; c < `CNN_CO; c++) begin
                r_acc[c] <= acc_next[c];
            end
        end
    end

    // bias and relu on the last tap of the window
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_conv <= '0;
        end else begin
            o_conv.valid <= r_tap.valid && r_tap.last_tap;
            if (r_tap.valid && r_tap.last_tap) begin
                o_conv.last_quad <= r_tap.last_quad;
                o_conv.pool      <= r_tap.pool;
                for (int c = 0; c < `CNN_CO; c++) begin
                    o_conv.fmap[c] <= biased[c][`CNN_ACC_W-1] ? '0
                                                             : biased[c][`CNN_FMAP_W-1:0];
                end
            end
        end
    end

endmodule

//--- cnn_max_pool.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_max_pool (
    input  logic               clk,
    input  logic               reset_n,
    input  cnn_pkg::conv_out_t i_conv,
    input  cnn_pkg::res_rd_t   i_res_rd,
    output cnn_pkg::fmap_t     o_res_data,
    output logic               o_last_wr
);

    cnn_pkg::fmap_t r_max   [`CNN_CO];
    cnn_pkg::fmap_t win_max [`CNN_CO];
    cnn_pkg::fmap_t res_mem [`CNN_CO][`CNN_NPOOL];

    always_comb begin
        for (int c = 0; c < `CNN_CO; c++) begin
            win_max[c] = (i_conv.fmap[c] > r_max[c]) ? i_conv.fmap[c] : r_max[c];
        end
    end

    // relu output is never negative, so zero restarts the max
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int c = 0; c < `CNN_CO; c++) begin
                r_max[c] <= '0;
            end
        end else if (i_conv.valid) begin
            for (int c = 0; c < `CNN_CO; c++) begin
                r_max[c] <= i_conv.last_quad ? '0 : win_max[c];
            end
        end
    end

    // ==================================================
    // result memory
    // ==================================================
    always_ff @(posedge clk) begin
        if (i_conv.valid && i_conv.last_quad) begin
            for (int c = 0; c < `CNN_CO; c++) begin
                res_mem[c][i_conv.pool] <= win_max[c];
            end
        end
    end

    // final pool cell, tells the controller the run is over
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_last_wr <= 1'b0;
        end else begin
            o_last_wr <= i_conv.valid && i_conv.last_quad
                         && (i_conv.pool == cnn_pkg::pool_idx_t'(`CNN_NPOOL - 1));
        end
    end

    assign o_res_data = res_mem[i_res_rd.ch][i_res_rd.pool];

endmodule

//--- cnn_top.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [`CNN_ADDR_W-1:0] i_paddr,
    input  logic [`CNN_DATA_W-1:0] i_pwdata,
    output logic [`CNN_DATA_W-1:0] o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic                   o_irq
);

    cnn_pkg::ctrl_state_t           state;
    cnn_pkg::pix_wr_t               pix_wr;
    cnn_pkg::tap_t                  tap;
    cnn_pkg::conv_out_t             conv;
    cnn_pkg::res_rd_t               res_rd;
    cnn_pkg::fmap_t                 res_data;
    cnn_pkg::weight_t [`CNN_NW-1:0] weights;
    cnn_pkg::bias_t   [`CNN_CO-1:0] bias;
    logic start, run, scan_end, pool_last_wr;

    // ==================================================
    // control side
    // ==================================================
    cnn_apb_regs u_apb_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_state    (state),
        .o_start    (start),
        .o_pix_wr   (pix_wr),
        .o_weights  (weights),
        .o_bias     (bias),
        .o_res_rd   (res_rd),
        .i_res_data (res_data),
        .o_irq      (o_irq)
    );

    cnn_ctrl_fsm u_ctrl_fsm (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_start        (start),
        .i_scan_end     (scan_end),
        .i_pool_last_wr (pool_last_wr),
        .o_run          (run),
        .o_state        (state)
    );

    cnn_scan_counter u_scan_counter (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_run      (run),
        .o_tap      (tap),
        .o_scan_end (scan_end)
    );

    // ==================================================
    // data path
    // ==================================================
    cnn_window_conv u_window_conv (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_pix_wr  (pix_wr),
        .i_tap     (tap),
        .i_weights (weights),
        .i_bias    (bias),
        .o_conv    (conv)
    );

    cnn_max_pool u_max_pool (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_conv     (conv),
        .i_res_rd   (res_rd),
        .o_res_data (res_data),
        .o_last_wr  (pool_last_wr)
    );

endmodule

//--- cnn_checker.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_checker (
    input  logic                   clk,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic                   i_pready,
    input  logic [`CNN_ADDR_W-1:0] i_paddr,
    input  logic [`CNN_DATA_W-1:0] i_prdata,
    input  logic                   i_pslverr,
    input  logic                   i_irq,
    input  logic                   i_chk_acc,
    input  logic                   i_chk_quiet,
    input  logic                   i_chk_irq,
    input  logic [`CNN_DATA_W-1:0] i_exp_data,
    input  logic                   i_exp_err,
    input  int                     i_line,
    output int                     o_pass_cnt,
    output int                     o_fail_cnt
);

    initial begin
        o_pass_cnt = 0;
        o_fail_cnt = 0;
    end

    task automatic compare_value(input string name, input logic [`CNN_DATA_W-1:0] exp_v,
                                 input logic [`CNN_DATA_W-1:0] act_v, inout bit ok);
        if (act_v !== exp_v) begin
            $display("FAIL time=%0t signal=%s expected=0x%08h actual=0x%08h line=%0d",
                     $time, name, exp_v, act_v, i_line);
            ok = 1'b0;
        end
    endtask

    // ==================================================
    // compare on the completing access edge
    // ==================================================
    always @(posedge clk) begin : compare_blk
        bit ok;
        ok = 1'b1;
        if (i_chk_irq) begin
            compare_value("o_irq", {31'b0, i_exp_data[0]}, {31'b0, i_irq}, ok);
            if (ok) begin
                $display("PASS line %0d irq=%0b", i_line, i_irq);
                o_pass_cnt <= o_pass_cnt + 1;
            end else begin
                o_fail_cnt <= o_fail_cnt + 1;
            end
        end else if (i_chk_acc && i_psel && i_penable) begin
            // no wait states, ready is up in the first access cycle
            compare_value("o_pready", 32'd1, {31'b0, i_pready}, ok);
            compare_value("o_pslverr", {31'b0, i_exp_err}, {31'b0, i_pslverr}, ok);
            // write data has nothing to compare against
            if (!i_pwrite) begin
                compare_value("o_prdata", i_exp_data, i_prdata, ok);
            end
            if (!ok) begin
                o_fail_cnt <= o_fail_cnt + 1;
            end else if (!i_chk_quiet) begin
                $display("PASS line %0d %s 0x%03h", i_line, i_pwrite ? "write" : "read",
                         i_paddr);
                o_pass_cnt <= o_pass_cnt + 1;
            end
        end
    end

endmodule

//--- tb_cnn_top.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module tb_cnn_top;

    localparam int POLL_LIMIT   = 2000;
    localparam int ACCESS_LIMIT = 16;
    localparam int LINE_LIMIT   = 512;

    logic                   clk;
    logic                   reset_n;
    logic                   psel, penable, pwrite;
    logic [`CNN_ADDR_W-1:0] paddr;
    logic [`CNN_DATA_W-1:0] pwdata, prdata;
    logic                   pready, pslverr, irq;
    // expectations handed to the checker
    logic                   chk_acc, chk_quiet, chk_irq;
    logic [`CNN_DATA_W-1:0] exp_data;
    logic                   exp_err;
    int                     line_no;
    int                     pass_cnt, fail_cnt;
    int                     cycle_cnt;
    bit                     aborted;

    cnn_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr),
        .o_irq     (irq)
    );

    cnn_checker u_checker (
        .clk         (clk),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_pready    (pready),
        .i_paddr     (paddr),
        .i_prdata    (prdata),
        .i_pslverr   (pslverr),
        .i_irq       (irq),
        .i_chk_acc   (chk_acc),
        .i_chk_quiet (chk_quiet),
        .i_chk_irq   (chk_irq),
        .i_exp_data  (exp_data),
        .i_exp_err   (exp_err),
        .i_line      (line_no),
        .o_pass_cnt  (pass_cnt),
        .o_fail_cnt  (fail_cnt)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==================================================
    // APB driver
    // ==================================================
    task automatic apb_transfer(input logic wr, input logic [`CNN_ADDR_W-1:0] addr,
                                input logic [`CNN_DATA_W-1:0] wdata, input logic acc,
                                input logic quiet, input logic [`CNN_DATA_W-1:0] expd,
                                input logic expe, output logic [`CNN_DATA_W-1:0] rdata);
        int waited;
        @(posedge clk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= wr;
        paddr     <= addr;
        pwdata    <= wdata;
        chk_acc   <= acc;
        chk_quiet <= quiet;
        exp_data  <= expd;
        exp_err   <= expe;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!pready && waited < ACCESS_LIMIT);
        rdata = prdata;
        psel      <= 1'b0;
        penable   <= 1'b0;
        chk_acc   <= 1'b0;
        chk_quiet <= 1'b0;
        if (!pready) begin
            $display("APB access to 0x%03h saw no ready within %0d cycles", addr, ACCESS_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic check_irq(input logic value);
        @(posedge clk);
        chk_irq  <= 1'b1;
        exp_data <= {31'b0, value};
        @(posedge clk);
        chk_irq <= 1'b0;
    endtask

    // pixel i gets mul * i + off, one write per word
    task automatic fill_frame(input logic [`CNN_ADDR_W-1:0] base,
                              input logic [`CNN_DATA_W-1:0] off, input logic [`CNN_DATA_W-1:0] mul);
        logic [`CNN_ADDR_W-1:0] addr;
        logic [`CNN_DATA_W-1:0] rd;
        for (int i = 0; i < `CNN_NPIX && !aborted; i++) begin
            addr = base + 4 * i;
            apb_transfer(1'b1, addr, (mul * i + off) & 32'hFF, 1'b1, 1'b1, '0, 1'b0, rd);
        end
    endtask

    task automatic poll_status(input logic [`CNN_ADDR_W-1:0] addr,
                               input logic [`CNN_DATA_W-1:0] mask);
        int                     start;
        bit                     seen;
        logic [`CNN_DATA_W-1:0] rd;
        start = cycle_cnt;
        seen  = 1'b0;
        while (!seen && !aborted && cycle_cnt - start < POLL_LIMIT) begin
            apb_transfer(1'b0, addr, '0, 1'b0, 1'b0, '0, 1'b0, rd);
            seen = ((rd & mask) == mask);
        end
        if (seen) begin
            // one checked read once the bits are up
            apb_transfer(1'b0, addr, '0, 1'b1, 1'b0, mask, 1'b0, rd);
        end else if (!aborted) begin
            $display("timeout: STATUS did not show 0x%0h within %0d cycles", mask, POLL_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic run_line(input byte op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] flag);
        logic [`CNN_DATA_W-1:0] rd;
        case (op)
            "W": apb_transfer(1'b1, addr[`CNN_ADDR_W-1:0], data, 1'b1, 1'b0, '0, flag[0], rd);
            "R": apb_transfer(1'b0, addr[`CNN_ADDR_W-1:0], '0, 1'b1, 1'b0, data, flag[0], rd);
            "P": poll_status(addr[`CNN_ADDR_W-1:0], data);
            "I": check_irq(data[0]);
            "F": fill_frame(addr[`CNN_ADDR_W-1:0], data, flag);
            default: begin
                $display("unknown operation '%c' in cnn_golden.txt", op);
                aborted = 1'b1;
            end
        endcase
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int          fd;
        int          nf;
        int          lines_read;
        string       line;
        byte         op;
        logic [31:0] addr, data, flag;
        clk       = 1'b0;
        reset_n   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        chk_acc   = 1'b0;
        chk_quiet = 1'b0;
        chk_irq   = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        line_no   = 0;
        cycle_cnt = 0;
        aborted   = 1'b0;
        lines_read = 0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        fd = $fopen("cnn_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open cnn_golden.txt");
            aborted = 1'b1;
        end
        while (!aborted && fd != 0 && !$feof(fd) && lines_read < LINE_LIMIT) begin
            line = "";
            nf = $fgets(line, fd);
            lines_read++;
            line_no <= lines_read;
            if (nf > 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%c %h %h %h", op, addr, data, flag) == 4) begin
                    run_line(op, addr, data, flag);
                end
            end
        end
        if (fd != 0 && !aborted && lines_read >= LINE_LIMIT && !$feof(fd)) begin
            $display("cnn_golden.txt holds more than %0d lines", LINE_LIMIT);
            aborted = 1'b1;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("tests passed: %0d, failed: %0d, aborted: %0d", pass_cnt, fail_cnt, aborted);
        if (fail_cnt == 0 && !aborted && pass_cnt > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- cnn_golden.txt
# columns: op addr data flag, all hex. W write, R read (data expected), flag is the error flag
# P poll addr until data bits set, I check irq equals data, F fill 64 pixels data + flag * index
R 004 00000000 0
I 000 00000000 0
R 300 00000000 1
R 0A8 00000000 1
W 008 00000001 1
# kernels, channel 0 then channel 1, row major
W 040 00000001 0
W 044 FFFFFFFE 0
W 048 00000001 0
W 04C 00000002 0
W 050 00000003 0
W 054 FFFFFFFF 0
W 058 FFFFFFFF 0
W 05C 00000002 0
W 060 00000001 0
W 064 FFFFFFFF 0
W 068 00000000 0
W 06C 00000002 0
W 070 FFFFFFFD 0
W 074 00000001 0
W 078 FFFFFFFE 0
W 07C 00000000 0
W 080 FFFFFFFF 0
W 084 00000001 0
W 0A0 FFFFFF38 0
W 0A4 00000064 0
F 100 00000000 00000001
R 044 FFFFFFFE 0
R 070 FFFFFFFD 0
R 0A0 FFFFFF38 0
R 0A4 00000064 0
R 104 00000001 0
R 1FC 0000003F 0
# run 1, refused writes while busy
W 000 00000001 0
R 004 00000001 0
W 040 0000007F 1
W 180 000000AA 1
W 000 00000001 1
P 004 00000002 0
I 000 00000001 0
R 040 00000001 0
R 180 00000020 0
R 200 00000000 0
R 204 00000000 0
R 208 00000000 0
R 20C 00000013 0
R 210 0000001F 0
R 214 0000002B 0
R 218 00000073 0
R 21C 0000007F 0
R 220 0000008B 0
R 224 00000046 0
R 228 00000040 0
R 22C 0000003A 0
R 230 00000016 0
R 234 00000010 0
R 238 0000000A 0
R 23C 00000000 0
R 240 00000000 0
R 244 00000000 0
# run 2 with a new frame
F 100 00000003 00000002
R 1FC 00000081 0
W 000 00000001 0
I 000 00000000 0
R 004 00000001 0
P 004 00000002 0
I 000 00000001 0
R 200 00000040 0
R 204 00000058 0
R 208 00000070 0
R 20C 00000100 0
R 210 00000118 0
R 214 00000130 0
R 218 000001C0 0
R 21C 000001D8 0
R 220 000001F0 0
R 224 0000001F 0
R 228 00000013 0
R 22C 00000007 0
R 230 00000000 0
R 234 00000000 0
R 238 00000000 0
R 23C 00000000 0
R 240 00000000 0
R 244 00000000 0

//--- sources.f
+incdir+.
cnn_pkg.sv
cnn_apb_regs.sv
cnn_ctrl_fsm.sv
cnn_scan_counter.sv
cnn_window_conv.sv
cnn_max_pool.sv
cnn_top.sv
cnn_checker.sv
tb_cnn_top.sv

//--- Bender.yml
package:
  name: cnn_conv_stage

sources:
  - include_dirs:
      - .
    files:
      - cnn_pkg.sv
      - cnn_apb_regs.sv
      - cnn_ctrl_fsm.sv
      - cnn_scan_counter.sv
      - cnn_window_conv.sv
      - cnn_max_pool.sv
      - cnn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cnn_checker.sv
      - tb_cnn_top.sv
